// File: Bender.yml
package:
  name: ft245_sync_fifo

sources:
  - hw/ft245_pkg.sv
  - hw/afifo.sv
  - hw/ft245_phy_ctrl.sv
  - hw/ft245_sync_fifo.sv
  - target: test
    files:
      - bench/ft245_sva.sv
      - bench/tb_ft245_sync_fifo.sv

// File: bench/ft245_sva.sv
// bound assertions on the phy strobes, transmit hold and receive fifo guard
module ft245_sva (
	input logic ftdi_clk,
	input logic rst,
	input logic ftdi_oe_n,
	input logic ftdi_rd_n,
	input logic ftdi_wr_n,
	input logic ftdi_txe_n,
	input logic rx_wr,
	input logic rx_almost_full
);
	// read strobe only once the chip owns the bus
	rd_needs_oe: assert property (@(posedge ftdi_clk) disable iff (rst)
		!ftdi_rd_n |-> !ftdi_oe_n)
		else $error("rd_n low while oe_n high");

	// chip and bridge never drive the bus together
	no_bus_clash: assert property (@(posedge ftdi_clk) disable iff (rst)
		!(!ftdi_wr_n && !ftdi_oe_n))
		else $error("wr_n and oe_n both low");

	// one write in flight at most once almost full, so full is never written
	rx_guard: assert property (@(posedge ftdi_clk) disable iff (rst)
		(rx_wr && rx_almost_full) |=> !rx_wr)
		else $error("receive fifo written past almost full");

	// byte held until the chip takes it
	tx_hold: assert property (@(posedge ftdi_clk) disable iff (rst)
		(!ftdi_wr_n && ftdi_txe_n) |=> !ftdi_wr_n)
		else $error("wr_n released before txe_n went low");
endmodule

bind ft245_phy_ctrl ft245_sva phy_sva (
	.ftdi_clk       (ftdi_clk),
	.rst            (rst),
	.ftdi_oe_n      (ftdi_oe_n),
	.ftdi_rd_n      (ftdi_rd_n),
	.ftdi_wr_n      (ftdi_wr_n),
	.ftdi_txe_n     (ftdi_txe_n),
	.rx_wr          (rx_wr),
	.rx_almost_full (rx_almost_full)
);

// File: bench/tb_ft245_sync_fifo.sv
// testbench with clocks, ft245 chip model, host tasks, directed tests, checks and watchdog
module tb_ft245_sync_fifo import ft245_pkg::*; ();
	localparam int FTDI_PERIOD = 20;
	// bytes moved over all tests, scales the watchdog
	localparam int TOTAL_BYTES = 106;
	localparam int TIMEOUT     = 40 * TOTAL_BYTES * FTDI_PERIOD;
	// txe_n behavior of the chip model
	localparam int TXE_HIGH    = 0;
	localparam int TXE_LOW     = 1;
	localparam int TXE_RANDOM  = 2;

	logic       rst;
	logic       clk;
	logic       ftdi_clk;
	logic       in_fifo_rst;
	logic       in_fifo_rd;
	logic       in_fifo_empty;
	byte_t      in_fifo_data;
	logic       out_fifo_wr;
	logic       out_fifo_full;
	byte_t      out_fifo_data;
	wire byte_t ftdi_data;
	logic       ftdi_rde_n;
	logic       ftdi_txe_n;
	logic       ftdi_suspend_n;
	logic       ftdi_oe_n;
	logic       ftdi_rd_n;
	logic       ftdi_wr_n;
	logic       ftdi_siwu;

	// chip side bytes waiting, captured transmit bytes, expected bytes
	byte_t rx_q[$];
	byte_t cap_q[$];
	byte_t exp_q[$];
	byte_t chip_data;
	int    txe_mode;
	int    errors;
	int    checks;

	ft245_sync_fifo #(.FIFO_AW(4)) dut (.*);

	// chip drives only while oe_n is low
	assign ftdi_data = ftdi_oe_n ? 'z : chip_data;

	initial begin
		ftdi_clk = 1'b0;
		forever #(FTDI_PERIOD / 2) ftdi_clk = ~ftdi_clk;
	end

	initial begin
		clk = 1'b0;
		forever #7 clk = ~clk;
	end

	// chip model
	// strobes sampled at the falling edge, effect applied 2 after the rising edge
	always begin : chip_model
		logic  take;
		logic  put;
		byte_t bus;
		@(negedge ftdi_clk);
		take = ~ftdi_rd_n & ~ftdi_rde_n;
		put  = ~ftdi_wr_n & ~ftdi_txe_n;
		bus  = ftdi_data;
		@(posedge ftdi_clk);
		#2;
		if (take) begin
			void'(rx_q.pop_front());
		end
		if (put) begin
			cap_q.push_back(bus);
		end
		// rde_n low while anything is queued, head on the bus
		ftdi_rde_n = (rx_q.size() == 0);
		chip_data  = (rx_q.size() != 0) ? rx_q[0] : 8'h00;
		case (txe_mode)
			TXE_LOW:    ftdi_txe_n = 1'b0;
			TXE_RANDOM: ftdi_txe_n = 1'($urandom_range(0, 1));
			default:    ftdi_txe_n = 1'b1;
		endcase
	end

	initial begin : watchdog
		#(TIMEOUT);
		$display("timeout, the run did not finish within %0d time units", TIMEOUT);
		$display("tests failed");
		$finish;
	end

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s, got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic host_write(input byte_t b);
		@(posedge clk);
		#2;
		while (out_fifo_full) begin
			@(posedge clk);
			#2;
		end
		out_fifo_wr   = 1'b1;
		out_fifo_data = b;
		@(posedge clk);
		#2;
		out_fifo_wr = 1'b0;
	endtask

	task automatic host_read(output byte_t b);
		@(posedge clk);
		#2;
		while (in_fifo_empty) begin
			@(posedge clk);
			#2;
		end
		in_fifo_rd = 1'b1;
		@(posedge clk);
		#2;
		in_fifo_rd = 1'b0;
		// registered read port, byte valid the cycle after the pop
		b = in_fifo_data;
	endtask

	// random bytes into the chip queue and the expected queue
	task automatic load_rx(input int n);
		byte_t b;
		for (int i = 0; i < n; i++) begin
			b = byte_t'($urandom);
			rx_q.push_back(b);
			exp_q.push_back(b);
		end
	endtask

	task automatic drain_rx(input int n, input string what);
		byte_t got;
		for (int i = 0; i < n; i++) begin
			host_read(got);
			check_byte(got, exp_q.pop_front(), what);
		end
	endtask

	task automatic send_tx(input int n);
		byte_t b;
		for (int i = 0; i < n; i++) begin
			b = byte_t'($urandom);
			exp_q.push_back(b);
			host_write(b);
		end
	endtask

	task automatic check_capture(input string what);
		int n;
		n = exp_q.size();
		while (cap_q.size() < n) begin
			@(posedge ftdi_clk);
		end
		// extra cycles so a repeated byte would show up
		repeat (20) @(posedge ftdi_clk);
		check_flag(cap_q.size() == n, 1'b1, {what, " count"});
		for (int i = 0; i < n && i < cap_q.size(); i++) begin
			check_byte(cap_q[i], exp_q[i], what);
		end
		exp_q.delete();
		cap_q.delete();
	endtask

	task automatic check_rx_idle(input string what);
		// empty flag needs the synchronizer latency to settle
		repeat (8) @(posedge clk);
		#2;
		check_flag(in_fifo_empty, 1'b1, what);
	endtask

	task automatic test_reset();
		@(posedge ftdi_clk);
		#2;
		check_flag(in_fifo_empty, 1'b1, "in_fifo_empty after reset");
		check_flag(out_fifo_full, 1'b0, "out_fifo_full after reset");
		check_flag(ftdi_oe_n, 1'b1, "oe_n after reset");
		check_flag(ftdi_rd_n, 1'b1, "rd_n after reset");
		check_flag(ftdi_wr_n, 1'b1, "wr_n after reset");
		check_flag(ftdi_siwu, 1'b1, "siwu after reset");
	endtask

	task automatic test_rx_stream();
		load_rx(12);
		drain_rx(12, "rx_stream byte");
		check_rx_idle("in_fifo_empty after rx_stream");
	endtask

	task automatic test_tx_stream();
		txe_mode = TXE_LOW;
		send_tx(12);
		check_capture("tx_stream byte");
		txe_mode = TXE_HIGH;
	endtask

	task automatic test_tx_backpressure();
		txe_mode = TXE_RANDOM;
		send_tx(30);
		check_capture("tx_backpressure byte");
		txe_mode = TXE_HIGH;
	endtask

	task automatic test_rx_full();
		int left;
		load_rx(40);
		// host idle until the chip queue stops shrinking
		do begin
			left = rx_q.size();
			repeat (20) @(posedge ftdi_clk);
		end while (rx_q.size() != left);
		check_flag((40 - left) <= 16, 1'b1, "rx_full bytes taken with host idle");
		drain_rx(40, "rx_full byte");
		check_rx_idle("in_fifo_empty after rx_full");
	endtask

	task automatic test_rx_flush();
		load_rx(6);
		while (rx_q.size() != 0) begin
			@(posedge ftdi_clk);
		end
		repeat (6) @(posedge clk);
		#2;
		check_flag(in_fifo_empty, 1'b0, "in_fifo_empty before flush");
		// flush spans edges of both clocks
		in_fifo_rst = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		in_fifo_rst = 1'b0;
		exp_q.delete();
		repeat (2) @(posedge clk);
		#2;
		check_flag(in_fifo_empty, 1'b1, "in_fifo_empty after flush");
		load_rx(6);
		drain_rx(6, "byte after flush");
	endtask

	initial begin
		rst            = 1'b1;
		in_fifo_rst    = 1'b0;
		in_fifo_rd     = 1'b0;
		out_fifo_wr    = 1'b0;
		out_fifo_data  = 8'h00;
		ftdi_rde_n     = 1'b1;
		ftdi_txe_n     = 1'b1;
		ftdi_suspend_n = 1'b1;
		chip_data      = 8'h00;
		txe_mode       = TXE_HIGH;
		errors         = 0;
		checks         = 0;
		void'($urandom(50996));
		repeat (10) @(posedge ftdi_clk);
		#2;
		rst = 1'b0;
		test_reset();
		test_rx_stream();
		test_tx_stream();
		test_tx_backpressure();
		test_rx_full();
		test_rx_flush();
		$display("summary: %0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end
endmodule

// File: hw/afifo.sv
// dual clock byte fifo with gray pointers, two flop synchronizers, registered read port
module afifo import ft245_pkg::*; #(
	parameter int ADDR_W = FIFO_AW_DEFAULT
) (
	// write side
	input  logic  rst,
	input  logic  wr_clk,
	input  logic  wr_en,
	input  byte_t din,
	output logic  full,
	output logic  almost_full,
	// read side
	input  logic  rd_clk,
	input  logic  rd_en,
	output byte_t dout,
	output logic  empty
);
	localparam int DEPTH = 2 ** ADDR_W;

	// storage
	byte_t mem [DEPTH];

	// write domain
	logic [ADDR_W:0] wr_bin;
	logic [ADDR_W:0] wr_bin_next;
	logic [ADDR_W:0] wr_bin_ahead;
	logic [ADDR_W:0] wr_gray;
	logic [ADDR_W:0] wr_gray_next;
	logic [ADDR_W:0] rd_gray_wq1;
	logic [ADDR_W:0] rd_gray_wq2;
	logic [ADDR_W:0] rd_gray_full;
	logic            wr_inc;
	logic            full_next;
	logic            almost_full_next;

	// read domain
	logic [ADDR_W:0] rd_bin;
	logic [ADDR_W:0] rd_bin_next;
	logic [ADDR_W:0] rd_gray;
	logic [ADDR_W:0] rd_gray_next;
	logic [ADDR_W:0] wr_gray_rq1;
	logic [ADDR_W:0] wr_gray_rq2;
	logic            rd_inc;
	logic            empty_next;

	function automatic logic [ADDR_W:0] bin2gray(input logic [ADDR_W:0] b);
		return b ^ (b >> 1);
	endfunction

	// pushes while full are dropped
	assign wr_inc       = wr_en & ~full;
	assign wr_bin_next  = wr_bin + {{ADDR_W{1'b0}}, wr_inc};
	assign wr_bin_ahead = wr_bin_next + {{ADDR_W{1'b0}}, 1'b1};
	assign wr_gray_next = bin2gray(wr_bin_next);

	// read pointer one lap behind, top two gray bits inverted
	assign rd_gray_full = {~rd_gray_wq2[ADDR_W -: 2], rd_gray_wq2[ADDR_W-2:0]};
	assign full_next    = (wr_gray_next == rd_gray_full);

	// one free entry left, or none
	assign almost_full_next = full_next | (bin2gray(wr_bin_ahead) == rd_gray_full);

	always_ff @(posedge wr_clk) begin
		if (rst) begin
			wr_bin      <= '0;
			wr_gray     <= '0;
			rd_gray_wq1 <= '0;
			rd_gray_wq2 <= '0;
			full        <= 1'b0;
			almost_full <= 1'b0;
		end else begin
			wr_bin      <= wr_bin_next;
			wr_gray     <= wr_gray_next;
			// read pointer into write clock
			rd_gray_wq1 <= rd_gray;
			rd_gray_wq2 <= rd_gray_wq1;
			full        <= full_next;
			almost_full <= almost_full_next;
		end
	end

	always_ff @(posedge wr_clk) begin
		if (wr_inc) begin
			mem[wr_bin[ADDR_W-1:0]] <= din;
		end
	end

	// pops while empty are dropped
	assign rd_inc       = rd_en & ~empty;
	assign rd_bin_next  = rd_bin + {{ADDR_W{1'b0}}, rd_inc};
	assign rd_gray_next = bin2gray(rd_bin_next);
	assign empty_next   = (rd_gray_next == wr_gray_rq2);

	always_ff @(posedge rd_clk) begin
		if (rst) begin
			rd_bin      <= '0;
			rd_gray     <= '0;
			wr_gray_rq1 <= '0;
			wr_gray_rq2 <= '0;
			empty       <= 1'b1;
		end else begin
			rd_bin      <= rd_bin_next;
			rd_gray     <= rd_gray_next;
			// write pointer into read clock
			wr_gray_rq1 <= wr_gray;
			wr_gray_rq2 <= wr_gray_rq1;
			empty       <= empty_next;
		end
	end

	// popped byte appears the cycle after rd_en and stays until the next pop
	always_ff @(posedge rd_clk) begin
		if (rd_inc) begin
			dout <= mem[rd_bin[ADDR_W-1:0]];
		end
	end

endmodule

// File: hw/ft245_phy_ctrl.sv
// ft245 bus sequencer for receive and transmit bursts, chip strobes and fifo pulses
module ft245_phy_ctrl import ft245_pkg::*; (
	input  logic ftdi_clk,
	input  logic rst,
	// chip status
	input  logic ftdi_rde_n,
	input  logic ftdi_txe_n,
	input  logic ftdi_suspend_n,
	// chip strobes
	output logic ftdi_oe_n,
	output logic ftdi_rd_n,
	output logic ftdi_wr_n,
	// receive fifo
	output logic rx_wr,
	input  logic rx_almost_full,
	// transmit fifo
	output logic tx_rd,
	input  logic tx_empty
);
	phy_state_e state;

	logic rx_start;
	logic tx_start;
	logic rx_stop;
	logic tx_accept;

	// new bursts only while the chip is awake
	// receive needs room for the in-flight byte plus one
	assign rx_start = ~ftdi_rde_n & ftdi_suspend_n & ~rx_almost_full;
	assign tx_start = ~ftdi_txe_n & ftdi_suspend_n & ~tx_empty;

	// chip ran dry or fifo close to full
	assign rx_stop = ftdi_rde_n | rx_almost_full;

	// chip takes the bus byte at this edge
	assign tx_accept = ~ftdi_wr_n & ~ftdi_txe_n;

	// same condition the chip uses to retire a byte
	// so the fifo captures exactly what leaves the chip
	assign rx_wr = ~ftdi_rd_n & ~ftdi_rde_n;

	always_ff @(posedge ftdi_clk) begin
		if (rst) begin
			state     <= ST_IDLE;
			ftdi_oe_n <= 1'b1;
			ftdi_rd_n <= 1'b1;
			ftdi_wr_n <= 1'b1;
			tx_rd     <= 1'b0;
		end else begin
			// fifo pop is a single cycle pulse
			tx_rd <= 1'b0;

			case (state)
				ST_IDLE: begin
					ftdi_oe_n <= 1'b1;
					ftdi_rd_n <= 1'b1;
					ftdi_wr_n <= 1'b1;
					if (rx_start) begin
						// hand the bus to the chip
						ftdi_oe_n <= 1'b0;
						state     <= ST_READ_OE;
					end else if (tx_start) begin
						// first byte out of the transmit fifo
						tx_rd <= 1'b1;
						state <= ST_TX_FETCH;
					end
				end

				ST_READ_OE: begin
					// turnaround done, start pulling bytes
					ftdi_rd_n <= 1'b0;
					state     <= ST_READ;
				end

				ST_READ: begin
					if (rx_stop) begin
						// bus back to the bridge
						ftdi_oe_n <= 1'b1;
						ftdi_rd_n <= 1'b1;
						state     <= ST_IDLE;
					end
				end

				ST_TX_FETCH: begin
					// fifo output now holds the byte
					ftdi_wr_n <= 1'b0;
					state     <= ST_WRITE;
				end

				ST_WRITE: begin
					// txe_n high keeps wr_n and the byte in place
					if (tx_accept) begin
						ftdi_wr_n <= 1'b1;
						if (!tx_empty) begin
							tx_rd <= 1'b1;
							state <= ST_TX_FETCH;
						end else begin
							state <= ST_IDLE;
						end
					end
				end

				default: begin
					ftdi_oe_n <= 1'b1;
					ftdi_rd_n <= 1'b1;
					ftdi_wr_n <= 1'b1;
					state     <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hw/ft245_pkg.sv
// shared byte type, default fifo pointer width, phy sequencer state encoding
package ft245_pkg;

	// one data byte on the chip bus and in both fifos
	typedef logic [7:0] byte_t;

	// 9 bit pointers, 512 entries per fifo
	localparam int FIFO_AW_DEFAULT = 9;

	// phy sequencer states
	typedef enum logic [2:0] {
		// waiting for chip status, receive wins over transmit
		ST_IDLE     = 3'd0,
		// oe_n low, bus turnaround before rd_n
		ST_READ_OE  = 3'd1,
		// one byte per cycle while rd_n and rde_n are low
		ST_READ     = 3'd2,
		// transmit fifo pop in flight
		ST_TX_FETCH = 3'd3,
		// wr_n low, byte held on the bus until txe_n is low
		ST_WRITE    = 3'd4
	} phy_state_e;

endpackage

// File: hw/ft245_sync_fifo.sv
// bridge top level with receive and transmit async fifos, phy sequencer and data bus driver
module ft245_sync_fifo import ft245_pkg::*; #(
	parameter int FIFO_AW = FIFO_AW_DEFAULT
) (
	input  logic       rst,
	input  logic       clk,
	// host receive side, clk domain
	input  logic       in_fifo_rst,
	input  logic       in_fifo_rd,
	output logic       in_fifo_empty,
	output byte_t      in_fifo_data,
	// host transmit side, clk domain
	input  logic       out_fifo_wr,
	output logic       out_fifo_full,
	input  byte_t      out_fifo_data,
	// chip side, ftdi_clk domain
	input  logic       ftdi_clk,
	inout  wire byte_t ftdi_data,
	input  logic       ftdi_rde_n,
	input  logic       ftdi_txe_n,
	input  logic       ftdi_suspend_n,
	output logic       ftdi_oe_n,
	output logic       ftdi_rd_n,
	output logic       ftdi_wr_n,
	output logic       ftdi_siwu
);
	byte_t tx_byte;
	logic  rx_wr;
	logic  rx_almost_full;
	logic  tx_rd;
	logic  tx_empty;
	logic  in_fifo_flush;

	// bridge owns the bus unless the chip was given oe_n
	assign ftdi_data = ftdi_oe_n ? tx_byte : 'z;

	// wake-up not used
	assign ftdi_siwu = 1'b1;

	// flush hits both pointer sets, so hold it over edges of both clocks
	assign in_fifo_flush = rst | in_fifo_rst;

	// chip to host
	afifo #(
		.ADDR_W (FIFO_AW)
	) fifo_in (
		.rst         (in_fifo_flush),
		.wr_clk      (ftdi_clk),
		.wr_en       (rx_wr),
		.din         (ftdi_data),
		.full        (),
		.almost_full (rx_almost_full),
		.rd_clk      (clk),
		.rd_en       (in_fifo_rd),
		.dout        (in_fifo_data),
		.empty       (in_fifo_empty)
	);

	// host to chip
	afifo #(
		.ADDR_W (FIFO_AW)
	) fifo_out (
		.rst         (rst),
		.wr_clk      (clk),
		.wr_en       (out_fifo_wr),
		.din         (out_fifo_data),
		.full        (out_fifo_full),
		.almost_full (),
		.rd_clk      (ftdi_clk),
		.rd_en       (tx_rd),
		.dout        (tx_byte),
		.empty       (tx_empty)
	);

	ft245_phy_ctrl phy (
		.ftdi_clk       (ftdi_clk),
		.rst            (rst),
		.ftdi_rde_n     (ftdi_rde_n),
		.ftdi_txe_n     (ftdi_txe_n),
		.ftdi_suspend_n (ftdi_suspend_n),
		.ftdi_oe_n      (ftdi_oe_n),
		.ftdi_rd_n      (ftdi_rd_n),
		.ftdi_wr_n      (ftdi_wr_n),
		.rx_wr          (rx_wr),
		.rx_almost_full (rx_almost_full),
		.tx_rd          (tx_rd),
		.tx_empty       (tx_empty)
	);

endmodule

// File: src.f
hw/ft245_pkg.sv
hw/afifo.sv
hw/ft245_phy_ctrl.sv
hw/ft245_sync_fifo.sv
bench/ft245_sva.sv
bench/tb_ft245_sync_fifo.sv
